/* flist.f */
source/spn_pkg.sv
source/gf64_power.sv
source/sbox6.sv
source/spn_round.sv
source/spn_core.sv
sim/spn_core_sva.sv
sim/spn_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the spn_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module spn_core_tb \
  -f flist.f \
  -o spn_core_sim

# the simulator status is not trusted, the log decides
./obj_dir/spn_core_sim 2>&1 | tee sim.log || true

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation result: passed"
  exit 0
else
  echo "simulation result: failed"
  exit 1
fi

/* sim/spn_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module spn_core_sva (
  input logic                        clk,
  input logic                        arst_n,
  input logic                        start,
  input logic                        busy,
  input logic                        done,
  input spn_pkg::core_state_e        state_q,
  input logic [spn_pkg::BLOCK_W-1:0] block_q,
  input logic [spn_pkg::BLOCK_W-1:0] round_out
);

  logic [spn_pkg::BLOCK_W-1:0] block_next; // what the block register must hold next

  assign block_next = (state_q == spn_pkg::ROUND) ? round_out : block_q;

  a_done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // FINAL is reached only after all rounds of an accepted start
  a_done_after_rounds: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> $past(start && !busy, spn_pkg::ROUNDS + 1))
    else $error("done high without an accepted start ROUNDS+1 cycles before");

  a_idle_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !busy)
    else $error("busy still high after the done cycle");

  // a start during a run must not reload the block
  a_start_ignored: assert property (@(posedge clk) disable iff (!arst_n)
    (start && busy) |=> (block_q == $past(block_next)))
    else $error("start while busy disturbed the block register");

endmodule

bind spn_core spn_core_sva u_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .start     (start),
  .busy      (busy),
  .done      (done),
  .state_q   (state_q),
  .block_q   (block_q),
  .round_out (round_out)
);

`default_nettype wire

/* sim/spn_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module spn_core_tb;

  localparam int BW = spn_pkg::BLOCK_W;
  localparam int NUM_RND = 16;
  localparam int FIRST_RND = 3;
  localparam int NUM_ROWS = FIRST_RND + NUM_RND + 2;
  localparam int DRIVE_DLY = 2;
  localparam int LAT_LIMIT = spn_pkg::ROUNDS + 3;
  localparam int MAX_CYCLES = NUM_ROWS * (spn_pkg::ROUNDS + 4) + 40;
  localparam logic [BW-1:0] RND_KEY = 24'h3C96E1;

  logic clk;
  logic arst_n;
  logic start;
  logic [BW-1:0] plaintext;
  logic [BW-1:0] key_in;
  logic busy;
  logic done;
  logic [BW-1:0] ciphertext;

  string name_tab [NUM_ROWS];
  logic [BW-1:0] pt_tab [NUM_ROWS];
  logic [BW-1:0] key_tab [NUM_ROWS];
  bit zero_tab [NUM_ROWS];
  bit inject_tab [NUM_ROWS];
  int cmp_tab [NUM_ROWS]; // -1 when there is nothing to compare against
  logic [BW-1:0] ct_tab [NUM_ROWS];

  integer seed;
  int errors;
  int tests_run;
  int tests_failed;
  int cycle_cnt;

  spn_core UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key_in),
    .busy       (busy),
    .done       (done),
    .ciphertext (ciphertext)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic add_row(input int r, input string name, input logic [BW-1:0] pt,
                         input logic [BW-1:0] k, input bit zero, input bit inject, input int cmp);
    name_tab[r] = name;
    pt_tab[r] = pt;
    key_tab[r] = k;
    zero_tab[r] = zero;
    inject_tab[r] = inject;
    cmp_tab[r] = cmp;
  endtask

  task automatic build_table();
    add_row(0, "zero_block", '0, '0, 1'b1, 1'b0, -1);
    add_row(1, "fixed_block", 24'h123456, 24'hA5C3F0, 1'b0, 1'b0, -1);
    add_row(2, "start_mid_run", 24'h123456, 24'hA5C3F0, 1'b0, 1'b1, 1); // must match row 1
    for (int i = 0; i < NUM_RND; i++) begin
      add_row(FIRST_RND + i, $sformatf("rnd_%02d", i), BW'($random(seed)), RND_KEY,
              1'b0, 1'b0, -1);
    end
    add_row(NUM_ROWS - 2, "replay_rnd_03", pt_tab[FIRST_RND + 3], RND_KEY, 1'b0, 1'b0,
            FIRST_RND + 3);
    add_row(NUM_ROWS - 1, "replay_rnd_12", pt_tab[FIRST_RND + 12], RND_KEY, 1'b0, 1'b0,
            FIRST_RND + 12);
  endtask

  // one encryption, with latency and busy checked on the way
  task automatic run_cipher(input string name, input logic [BW-1:0] pt, input logic [BW-1:0] k,
                            input bit inject, output logic [BW-1:0] ct);
    int lat;
    bit seen;
    lat = 0;
    seen = 1'b0;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b1;
    plaintext = pt;
    key_in = k;
    @(posedge clk); // accepting edge
    #DRIVE_DLY;
    start = 1'b0;
    while (!seen && lat < LAT_LIMIT) begin
      @(negedge clk);
      lat++;
      if (done) begin
        seen = 1'b1;
      end
      check_value({name, " busy"}, 32'd1, 32'(busy));
      if (!seen) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (inject && lat == 3) begin
          start = 1'b1; // should be dropped by the core
          plaintext = pt ^ 24'hFFF000;
          key_in = ~k;
        end else begin
          start = 1'b0;
        end
      end
    end
    if (!seen) begin
      errors++;
      $display("%s: done never rose within %0d cycles of start", name, LAT_LIMIT);
    end else begin
      check_value({name, " latency"}, 32'(spn_pkg::ROUNDS + 1), 32'(lat));
    end
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    @(negedge clk);
    check_value({name, " done after"}, 32'd0, 32'(done));
    check_value({name, " busy after"}, 32'd0, 32'(busy));
    ct = ciphertext;
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    int errors_before;
    logic [BW-1:0] ct;
    arst_n = 1'b0;
    start = 1'b0;
    plaintext = '0;
    key_in = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    seed = 21325;
    build_table();

    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(negedge clk);
    errors_before = errors;
    check_value("after_reset busy", 32'd0, 32'(busy));
    check_value("after_reset done", 32'd0, 32'(done));
    check_value("after_reset ciphertext", 32'd0, 32'(ciphertext));
    report_test("after_reset", errors_before);

    for (int r = 0; r < NUM_ROWS; r++) begin
      errors_before = errors;
      run_cipher(name_tab[r], pt_tab[r], key_tab[r], inject_tab[r], ct);
      ct_tab[r] = ct;
      if (zero_tab[r]) begin
        check_value(name_tab[r], 32'd0, 32'(ct));
      end
      if (cmp_tab[r] >= 0) begin
        check_value(name_tab[r], 32'(ct_tab[cmp_tab[r]]), 32'(ct));
      end
      report_test(name_tab[r], errors_before);
    end

    // a bijective round function cannot map two plaintexts to one ciphertext
    errors_before = errors;
    for (int i = FIRST_RND; i < FIRST_RND + NUM_RND; i++) begin
      for (int j = i + 1; j < FIRST_RND + NUM_RND; j++) begin
        if (ct_tab[i] === ct_tab[j]) begin
          errors++;
          $display("%s and %s gave the same ciphertext %h", name_tab[i], name_tab[j],
                   ct_tab[i]);
        end
      end
    end
    report_test("distinct_random", errors_before);

    $display("summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/gf64_power.sv */
`timescale 1ns/1ps
`default_nettype none

module gf64_power (
  input  logic [spn_pkg::SBOX_W-1:0] a,
  output logic [spn_pkg::SBOX_W-1:0] b
);

  logic [1:0] x0;
  logic [1:0] x1;
  logic [1:0] x2;
  logic [1:0] y0;
  logic [1:0] y1;
  logic [1:0] y2;
  logic [1:0] y3;
  logic [1:0] y4;
  logic [1:0] y5;
  logic [1:0] t [0:14];

  assign x0 = a[1:0];
  assign x1 = a[3:2];
  assign x2 = a[5:4];

  assign y0 = spn_pkg::gf4_sq(x0);
  assign y1 = spn_pkg::gf4_sq(x1);
  assign y2 = spn_pkg::gf4_sq(x2);
  assign y3 = spn_pkg::gf4_mul(x1, x2);
  assign y4 = spn_pkg::gf4_mul(x0, x2);
  assign y5 = spn_pkg::gf4_mul(x0, x1);

  // linear terms
  assign t[0] = x0;
  assign t[1] = x1;
  assign t[2] = x2;
  // cube-gated cross terms
  assign t[3] = spn_pkg::gf4_cube_gate(x0, x1);
  assign t[4] = spn_pkg::gf4_cube_gate(x0, x2);
  assign t[5] = spn_pkg::gf4_cube_gate(x1, x0);
  assign t[6] = spn_pkg::gf4_cube_gate(x1, x2);
  assign t[7] = spn_pkg::gf4_cube_gate(x2, x0);
  assign t[8] = spn_pkg::gf4_cube_gate(x2, x1);
  // square products
  assign t[9] = spn_pkg::gf4_mul(y0, y1);
  assign t[10] = spn_pkg::gf4_mul(y0, y2);
  assign t[11] = spn_pkg::gf4_mul(y1, y2);
  // degree-four mixed terms
  assign t[12] = spn_pkg::gf4_mul(y0, y3);
  assign t[13] = spn_pkg::gf4_mul(y1, y4);
  assign t[14] = spn_pkg::gf4_mul(y2, y5);

  assign b[1:0] = spn_pkg::gf4_cmul(t[0], 2'd3) ^
                  spn_pkg::gf4_cmul(t[1], 2'd0) ^
                  spn_pkg::gf4_cmul(t[2], 2'd2) ^
                  spn_pkg::gf4_cmul(t[3], 2'd1) ^
                  spn_pkg::gf4_cmul(t[4], 2'd2) ^
                  spn_pkg::gf4_cmul(t[5], 2'd0) ^
                  spn_pkg::gf4_cmul(t[6], 2'd2) ^
                  spn_pkg::gf4_cmul(t[7], 2'd0) ^
                  spn_pkg::gf4_cmul(t[8], 2'd0) ^
                  spn_pkg::gf4_cmul(t[9], 2'd0) ^
                  spn_pkg::gf4_cmul(t[10], 2'd1) ^
                  spn_pkg::gf4_cmul(t[11], 2'd3) ^
                  spn_pkg::gf4_cmul(t[12], 2'd0) ^
                  spn_pkg::gf4_cmul(t[13], 2'd1) ^
                  spn_pkg::gf4_cmul(t[14], 2'd2);

  assign b[3:2] = spn_pkg::gf4_cmul(t[0], 2'd2) ^
                  spn_pkg::gf4_cmul(t[1], 2'd3) ^
                  spn_pkg::gf4_cmul(t[2], 2'd0) ^
                  spn_pkg::gf4_cmul(t[3], 2'd0) ^
                  spn_pkg::gf4_cmul(t[4], 2'd0) ^
                  spn_pkg::gf4_cmul(t[5], 2'd2) ^
                  spn_pkg::gf4_cmul(t[6], 2'd1) ^
                  spn_pkg::gf4_cmul(t[7], 2'd2) ^
                  spn_pkg::gf4_cmul(t[8], 2'd0) ^
                  spn_pkg::gf4_cmul(t[9], 2'd1) ^
                  spn_pkg::gf4_cmul(t[10], 2'd3) ^
                  spn_pkg::gf4_cmul(t[11], 2'd0) ^
                  spn_pkg::gf4_cmul(t[12], 2'd2) ^
                  spn_pkg::gf4_cmul(t[13], 2'd0) ^
                  spn_pkg::gf4_cmul(t[14], 2'd1);

  assign b[5:4] = spn_pkg::gf4_cmul(t[0], 2'd0) ^
                  spn_pkg::gf4_cmul(t[1], 2'd2) ^
                  spn_pkg::gf4_cmul(t[2], 2'd3) ^
                  spn_pkg::gf4_cmul(t[3], 2'd2) ^
                  spn_pkg::gf4_cmul(t[4], 2'd0) ^
                  spn_pkg::gf4_cmul(t[5], 2'd0) ^
                  spn_pkg::gf4_cmul(t[6], 2'd0) ^
                  spn_pkg::gf4_cmul(t[7], 2'd1) ^
                  spn_pkg::gf4_cmul(t[8], 2'd2) ^
                  spn_pkg::gf4_cmul(t[9], 2'd3) ^
                  spn_pkg::gf4_cmul(t[10], 2'd0) ^
                  spn_pkg::gf4_cmul(t[11], 2'd1) ^
                  spn_pkg::gf4_cmul(t[12], 2'd1) ^
                  spn_pkg::gf4_cmul(t[13], 2'd2) ^
                  spn_pkg::gf4_cmul(t[14], 2'd0);

endmodule

`default_nettype wire

/* source/sbox6.sv */
`timescale 1ns/1ps
`default_nettype none

module sbox6 (
  input  logic [spn_pkg::SBOX_W-1:0] x,
  output logic [spn_pkg::SBOX_W-1:0] y
);

  logic [spn_pkg::SBOX_W-1:0] z; // tower-field image of x
  logic [spn_pkg::SBOX_W-1:0] w; // x^52 in tower basis
  logic [spn_pkg::SBOX_W-1:0] p; // back in polynomial basis
  logic par;

  // polynomial basis to tower basis
  assign z[0] = x[0];
  assign z[1] = x[0] ^ x[2] ^ x[3] ^ x[4];
  assign z[2] = x[0] ^ x[1] ^ x[3];
  assign z[3] = x[0] ^ x[2];
  assign z[4] = x[0] ^ x[3] ^ x[4] ^ x[5];
  assign z[5] = x[0] ^ x[1] ^ x[5];

  gf64_power u_power (
    .a (z),
    .b (w)
  );

  // tower basis back to polynomial basis
  assign p[0] = w[0] ^ w[1] ^ w[2] ^ w[5];
  assign p[1] = w[1] ^ w[2] ^ w[3] ^ w[5];
  assign p[2] = w[0] ^ w[2];
  assign p[3] = w[1] ^ w[2] ^ w[5];
  assign p[4] = w[2] ^ w[3] ^ w[4];
  assign p[5] = w[0] ^ w[1] ^ w[4] ^ w[5];

  // affine correction, keyed on the raw input
  assign par = x[2] ^ x[4];
  assign y = p ^ {spn_pkg::SBOX_W{par}};

endmodule

`default_nettype wire

/* source/spn_core.sv */
`timescale 1ns/1ps
`default_nettype none

module spn_core (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        start,
  input  logic [spn_pkg::BLOCK_W-1:0] plaintext,
  input  logic [spn_pkg::BLOCK_W-1:0] key,
  output logic                        busy,
  output logic                        done,
  output logic [spn_pkg::BLOCK_W-1:0] ciphertext
);

  localparam int KR = spn_pkg::KEY_ROT;
  localparam int BW = spn_pkg::BLOCK_W;
  localparam logic [spn_pkg::ROUND_CNT_W-1:0] LAST_RND =
    spn_pkg::ROUND_CNT_W'(spn_pkg::ROUNDS - 1);

  spn_pkg::core_state_e state_q;

  logic [spn_pkg::ROUND_CNT_W-1:0] rnd_cnt;
  logic [BW-1:0] block_q;
  logic [BW-1:0] key_q;
  logic [BW-1:0] round_out;
  logic [BW-1:0] key_rot;
  logic accept;

  assign accept = start && (state_q == spn_pkg::IDLE); // start while busy is dropped
  assign key_rot = {key_q[BW-KR-1:0], key_q[BW-1:BW-KR]};

  spn_round u_round (
    .state_in  (block_q),
    .round_key (key_q),
    .state_out (round_out)
  );

  // controller
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= spn_pkg::IDLE;
      rnd_cnt <= '0;
    end else begin
      case (state_q)
        spn_pkg::IDLE: begin
          if (accept) begin
            state_q <= spn_pkg::ROUND;
            rnd_cnt <= '0;
          end
        end
        spn_pkg::ROUND: begin
          rnd_cnt <= rnd_cnt + 1'b1;
          if (rnd_cnt == LAST_RND) begin
            state_q <= spn_pkg::FINAL;
          end
        end
        spn_pkg::FINAL: begin
          state_q <= spn_pkg::IDLE;
        end
        default: begin
          state_q <= spn_pkg::IDLE;
        end
      endcase
    end
  end

  // block and key registers
  always_ff @(posedge clk) begin
    if (accept) begin
      block_q <= plaintext;
      key_q <= key;
    end else if (state_q == spn_pkg::ROUND) begin
      block_q <= round_out;
      key_q <= key_rot; // next round key
    end
  end

  // whitening with the key left after the last rotation
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ciphertext <= '0;
    end else if (state_q == spn_pkg::FINAL) begin
      ciphertext <= block_q ^ key_q;
    end
  end

  assign busy = (state_q != spn_pkg::IDLE);
  assign done = (state_q == spn_pkg::FINAL); // ciphertext updates on the edge closing this cycle

endmodule

`default_nettype wire

/* source/spn_pkg.sv */
`default_nettype none

package spn_pkg;

  localparam int BLOCK_W = 24;
  localparam int SBOX_W = 6;
  localparam int NUM_SBOX = BLOCK_W / SBOX_W;
  localparam int ROUNDS = 8;
  localparam int KEY_ROT = 5;
  localparam int ROUND_CNT_W = $clog2(ROUNDS);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ROUND = 2'd1,
    FINAL = 2'd2 // output whitening
  } core_state_e;

  // gf(4) squaring, linear over gf(2)
  function automatic logic [1:0] gf4_sq(input logic [1:0] a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic logic [1:0] gf4_mul(input logic [1:0] a, input logic [1:0] b);
    logic t;
    logic [1:0] c;
    t = a[1] & b[1]; // shared high-high product
    c[0] = (a[0] & b[0]) ^ t;
    c[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ t;
    return c;
  endfunction

  // a^3 is 1 for any nonzero a, so the product reduces to a gate on b
  function automatic logic [1:0] gf4_cube_gate(input logic [1:0] a, input logic [1:0] b);
    logic g;
    g = a[0] ^ (~a[0] & a[1]);
    return {g & b[1], g & b[0]};
  endfunction

  function automatic logic [1:0] gf4_cmul(input logic [1:0] a, input logic [1:0] c);
    logic [1:0] r;
    case (c)
      2'd0: r = 2'b00;
      2'd1: r = a;
      2'd2: r = {a[0] ^ a[1], a[1]};
      default: r = {a[0], a[0] ^ a[1]};
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

/* source/spn_round.sv */
`timescale 1ns/1ps
`default_nettype none

module spn_round (
  input  logic [spn_pkg::BLOCK_W-1:0] state_in,
  input  logic [spn_pkg::BLOCK_W-1:0] round_key,
  output logic [spn_pkg::BLOCK_W-1:0] state_out
);

  localparam int PERM_MUL = 7; // coprime to 24, so i -> 7i mod 24 is a bijection

  logic [spn_pkg::BLOCK_W-1:0] keyed;
  logic [spn_pkg::BLOCK_W-1:0] subst;

  assign keyed = state_in ^ round_key;

  // substitution layer
  for (genvar s = 0; s < spn_pkg::NUM_SBOX; s++) begin : g_sbox
    sbox6 u_sbox (
      .x (keyed[s*spn_pkg::SBOX_W +: spn_pkg::SBOX_W]),
      .y (subst[s*spn_pkg::SBOX_W +: spn_pkg::SBOX_W])
    );
  end

  // bit permutation, pure wiring
  for (genvar i = 0; i < spn_pkg::BLOCK_W; i++) begin : g_perm
    assign state_out[(PERM_MUL * i) % spn_pkg::BLOCK_W] = subst[i];
  end

endmodule

`default_nettype wire
